// ==== Makefile ====
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all run clean

all: obj_dir/Vup_bram_sys_tb

obj_dir/Vup_bram_sys_tb: up_bram_sys.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module up_bram_sys_tb -f up_bram_sys.f

run: obj_dir/Vup_bram_sys_tb
	./obj_dir/Vup_bram_sys_tb

clean:
	rm -rf obj_dir

// ==== dv/up_bram_sys_tb.sv ====
// Testbench for the shared BRAM subsystem; runs a stimulus table against a shadow memory model.
`default_nettype none

module up_bram_sys_tb
    import up_bram_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT  = 2000;  // Cycles allowed for any single wait.
    localparam int NUM_ROWS = 21;

    typedef enum logic [2:0] {
        ROW_HOST_WR, ROW_HOST_RD, ROW_FILL, ROW_COPY, ROW_START_BUSY
    } row_kind_e;

    // Overlap lets a mover row run in the background, or a host row run beside it.
    typedef struct packed {
        row_kind_e         kind;
        logic              overlap;
        logic              rnd;      // Replace data with a random word.
        logic [ADDR_W-1:0] addr;     // Host address, or mover source.
        logic [ADDR_W-1:0] dst;
        logic [ADDR_W:0]   len;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] data;
    } row_t;

    // kind, overlap, rnd, addr, dst, len, be, data
    row_t rows [NUM_ROWS] = '{
        '{ROW_HOST_RD,    1'b0, 1'b0, 10'd10,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_HOST_RD,    1'b0, 1'b0, 10'd1023, 10'd0,   11'd0,  4'h0, 32'h0},
        '{ROW_HOST_WR,    1'b0, 1'b1, 10'd20,  10'd0,    11'd0,  4'hf, 32'h0},
        '{ROW_HOST_WR,    1'b0, 1'b0, 10'd20,  10'd0,    11'd0,  4'h5, 32'ha5a5_5a5a},
        '{ROW_HOST_RD,    1'b0, 1'b0, 10'd20,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_HOST_WR,    1'b0, 1'b1, 10'd21,  10'd0,    11'd0,  4'h8, 32'h0},
        '{ROW_HOST_RD,    1'b0, 1'b0, 10'd21,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_FILL,       1'b0, 1'b0, 10'd0,   10'd100,  11'd8,  4'h0, 32'hcafe_f00d},
        '{ROW_HOST_WR,    1'b0, 1'b1, 10'd98,  10'd0,    11'd0,  4'hf, 32'h0},
        '{ROW_HOST_WR,    1'b0, 1'b1, 10'd109, 10'd0,    11'd0,  4'hf, 32'h0},
        '{ROW_COPY,       1'b0, 1'b0, 10'd98,  10'd1018, 11'd12, 4'h0, 32'h0},
        '{ROW_COPY,       1'b0, 1'b0, 10'd20,  10'd400,  11'd2,  4'h0, 32'h0},
        '{ROW_FILL,       1'b1, 1'b1, 10'd0,   10'd600,  11'd16, 4'h0, 32'h0},
        '{ROW_HOST_WR,    1'b1, 1'b1, 10'd50,  10'd0,    11'd0,  4'hf, 32'h0},
        '{ROW_HOST_RD,    1'b1, 1'b0, 10'd50,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_HOST_RD,    1'b1, 1'b0, 10'd100, 10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_HOST_WR,    1'b1, 1'b1, 10'd20,  10'd0,    11'd0,  4'h3, 32'h0},
        '{ROW_HOST_RD,    1'b1, 1'b0, 10'd20,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_HOST_RD,    1'b0, 1'b0, 10'd50,  10'd0,    11'd0,  4'h0, 32'h0},
        '{ROW_START_BUSY, 1'b0, 1'b0, 10'd0,   10'd700,  11'd6,  4'h0, 32'h1234_5678},
        '{ROW_FILL,       1'b0, 1'b0, 10'd0,   10'd800,  11'd0,  4'h0, 32'hdead_beef}
    };

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] host_wr_addr;
    logic [BE_W-1:0]   host_wr_be;
    logic              host_wr_req;
    logic [DATA_W-1:0] host_wr_din;
    logic              host_wr_ack;
    logic [ADDR_W-1:0] host_rd_addr;
    logic              host_rd_req;
    logic [DATA_W-1:0] host_rd_dout;
    logic              host_rd_ack;
    logic              cmd_start;
    mover_op_e         cmd_op;
    logic [ADDR_W-1:0] cmd_src;
    logic [ADDR_W-1:0] cmd_dst;
    logic [ADDR_W:0]   cmd_len;
    logic [DATA_W-1:0] cmd_fill;
    logic              cmd_busy;
    logic              cmd_done;

    logic [DATA_W-1:0] shadow [MEM_DEPTH];  // Expected RAM contents.
    row_t              row;
    int                seed = 32'ha569;
    int                done_count = 0;
    int                done_base;
    logic              pending = 1'b0;     // A mover command is still running.
    mover_op_e         pend_op;
    logic [ADDR_W-1:0] pend_src;
    logic [ADDR_W-1:0] pend_dst;
    logic [ADDR_W:0]   pend_len;
    logic [DATA_W-1:0] pend_fill;

    up_bram_sys up_bram_sys_i (.*);

    always #5 clk = ~clk;

    // Counts done pulses by their value just before each rising edge.
    always @(posedge clk) begin
        if (!rst && cmd_done) begin
            done_count <= done_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic check_value(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s: got 0x%08h, expected 0x%08h",
                     $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s did not arrive within %0d cycles.", $time, what, TIMEOUT);
        $display("Simulation FAILED");
        $fatal(1, "Wait timed out.");
    endtask

    //////////////////////////////////////////////////
    // Host bus and mover command drivers
    //////////////////////////////////////////////////

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                              input logic [DATA_W-1:0] data);
        int n;
        @(negedge clk);
        host_wr_addr = addr;
        host_wr_be   = be;
        host_wr_din  = data;
        host_wr_req  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("host write ack");
        end while (!host_wr_ack);
        @(negedge clk);
        host_wr_req = 1'b0;  // Dropped in the cycle after the ack.
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) shadow[addr][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr);
        int n;
        logic [DATA_W-1:0] data;
        @(negedge clk);
        host_rd_addr = addr;
        host_rd_req  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("host read ack");
        end while (!host_rd_ack);
        data = host_rd_dout;  // Read data is valid only in the ack cycle.
        @(negedge clk);
        host_rd_req = 1'b0;
        check_value(data, shadow[addr], $sformatf("host read at 0x%03h", addr));
    endtask

    // Reads the range and one word on each side of it.
    task automatic verify_range(input logic [ADDR_W-1:0] start, input logic [ADDR_W:0] len);
        logic [ADDR_W-1:0] a;
        a = start - 10'd1;
        for (int i = 0; i < int'(len) + 2; i++) begin
            host_read(a);
            a = a + 10'd1;
        end
    endtask

    task automatic start_mover(input mover_op_e op, input logic [ADDR_W-1:0] src,
                               input logic [ADDR_W-1:0] dst, input logic [ADDR_W:0] len,
                               input logic [DATA_W-1:0] fill);
        @(negedge clk);
        cmd_op    = op;
        cmd_src   = src;
        cmd_dst   = dst;
        cmd_len   = len;
        cmd_fill  = fill;
        cmd_start = 1'b1;
        done_base = done_count;
        @(negedge clk);
        cmd_start = 1'b0;
        check_value(32'(cmd_busy), 32'd1, "cmd_busy after start");
        pend_op   = op;
        pend_src  = src;
        pend_dst  = dst;
        pend_len  = len;
        pend_fill = fill;
        pending   = 1'b1;
    endtask

    // Waits out a running command, then updates the shadow word by word in ascending order.
    task automatic finish_mover();
        int n;
        logic [ADDR_W-1:0] s;
        logic [ADDR_W-1:0] d;
        if (pending) begin
            n = 0;
            while (cmd_busy) begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) report_timeout("cmd_done");
            end
            @(negedge clk);
            check_value(done_count, done_base + 1, "cmd_done pulse count");
            s = pend_src;
            d = pend_dst;
            for (int i = 0; i < int'(pend_len); i++) begin
                shadow[d] = (pend_op == OP_COPY) ? shadow[s] : pend_fill;
                s = s + 10'd1;
                d = d + 10'd1;
            end
            pending = 1'b0;
            verify_range(pend_dst, pend_len);
        end
    endtask

    // A second start lands while busy and must leave its own range untouched.
    task automatic ignored_start_check(input row_t r);
        start_mover(OP_FILL, '0, r.dst, r.len, r.data);
        repeat (2) @(negedge clk);
        check_value(32'(cmd_busy), 32'd1, "cmd_busy before second start");
        cmd_dst   = r.dst + 10'd16;
        cmd_fill  = ~r.data;
        cmd_start = 1'b1;
        @(negedge clk);
        cmd_start = 1'b0;
        finish_mover();
        verify_range(r.dst + 10'd16, r.len);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        host_wr_addr = '0;
        host_wr_be   = '0;
        host_wr_req  = 1'b0;
        host_wr_din  = '0;
        host_rd_addr = '0;
        host_rd_req  = 1'b0;
        cmd_start    = 1'b0;
        cmd_op       = OP_FILL;
        cmd_src      = '0;
        cmd_dst      = '0;
        cmd_len      = '0;
        cmd_fill     = '0;
        for (int i = 0; i < MEM_DEPTH; i++) shadow[i] = '0;  // RAM starts cleared.
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value(32'({host_wr_ack, host_rd_ack, cmd_busy, cmd_done}), 32'd0,
                    "outputs after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            if (row.rnd) row.data = $random(seed);
            if (!row.overlap || (row.kind != ROW_HOST_WR && row.kind != ROW_HOST_RD)) begin
                finish_mover();
            end
            case (row.kind)
                ROW_HOST_WR:    host_write(row.addr, row.be, row.data);
                ROW_HOST_RD:    host_read(row.addr);
                ROW_FILL:       start_mover(OP_FILL, row.addr, row.dst, row.len, row.data);
                ROW_COPY:       start_mover(OP_COPY, row.addr, row.dst, row.len, row.data);
                ROW_START_BUSY: ignored_start_check(row);
                default:        ;
            endcase
            if (!row.overlap) finish_mover();
        end
        finish_mover();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== up_bram_sys.f ====
verilog/up_bram_pkg.sv
verilog/up_bus_if.sv
verilog/up_bram.sv
verilog/up_bus_arbiter.sv
verilog/block_mover.sv
verilog/up_bram_sys.sv
dv/up_bram_sys_tb.sv

// ==== verilog/block_mover.sv ====
// Command engine that fills or copies a range of RAM words through a bus master port.
`default_nettype none

module block_mover
    import up_bram_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              cmd_start,
    input  wire mover_op_e         cmd_op,
    input  wire logic [ADDR_W-1:0] cmd_src,
    input  wire logic [ADDR_W-1:0] cmd_dst,
    input  wire logic [ADDR_W:0]   cmd_len,   // Word count, up to MEM_DEPTH.
    input  wire logic [DATA_W-1:0] cmd_fill,
    output logic                   cmd_busy,
    output logic                   cmd_done,
    up_bus_if.master               bus
);

    mover_state_e      state;
    mover_op_e         op_q;
    logic [ADDR_W-1:0] src_q;      // Next source word, wraps at the top of memory.
    logic [ADDR_W-1:0] dst_q;
    logic [ADDR_W:0]   remaining;  // Words still to be written.
    logic [DATA_W-1:0] data_q;     // Fill value or the word just read.

    assign bus.rd_addr = src_q;
    assign bus.wr_addr = dst_q;
    assign bus.wr_din  = data_q;
    assign bus.wr_be   = '1;  // Whole words only.

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= MV_IDLE;
            op_q       <= OP_FILL;
            src_q      <= '0;
            dst_q      <= '0;
            remaining  <= '0;
            cmd_busy   <= 1'b0;
            cmd_done   <= 1'b0;
            bus.wr_req <= 1'b0;
            bus.rd_req <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                MV_IDLE: begin
                    if (cmd_start) begin
                        op_q      <= cmd_op;
                        src_q     <= cmd_src;
                        dst_q     <= cmd_dst;
                        remaining <= cmd_len;
                        cmd_busy  <= 1'b1;
                        if (cmd_len == '0) begin
                            state <= MV_DONE;  // Nothing to move.
                        end else if (cmd_op == OP_COPY) begin
                            state <= MV_READ;
                        end else begin
                            state <= MV_WRITE;
                        end
                    end
                end
                MV_READ: begin
                    if (bus.rd_ack) begin
                        bus.rd_req <= 1'b0;
                        state      <= MV_WRITE;
                    end else if (!bus.rd_req) begin
                        bus.rd_req <= 1'b1;
                    end
                end
                MV_WRITE: begin
                    if (bus.wr_ack) begin
                        bus.wr_req <= 1'b0;
                        remaining  <= remaining - 1'b1;
                        src_q      <= src_q + 1'b1;
                        dst_q      <= dst_q + 1'b1;
                        if (remaining == 1) begin
                            state <= MV_DONE;
                        end else if (op_q == OP_COPY) begin
                            state <= MV_READ;
                        end
                        // A fill stays here and raises the next write after a gap.
                    end else if (!bus.wr_req) begin
                        bus.wr_req <= 1'b1;
                    end
                end
                MV_DONE: begin
                    cmd_busy <= 1'b0;
                    cmd_done <= 1'b1;  // Pulses as busy falls.
                    state    <= MV_IDLE;
                end
                default: state <= MV_IDLE;
            endcase
        end
    end

    // Data word: the fill value at start, or each word returned by a read.
    always_ff @(posedge clk) begin
        if (state == MV_IDLE && cmd_start) begin
            data_q <= cmd_fill;
        end else if (state == MV_READ && bus.rd_ack) begin
            data_q <= bus.rd_dout;
        end
    end

    // The count only moves down during a command and never wraps below zero.
    a_no_underflow : assert property (@(posedge clk) disable iff (rst)
        (cmd_busy && $past(cmd_busy)) |-> (remaining <= $past(remaining)))
        else $error("Mover remaining count underflowed.");

endmodule

`default_nettype wire

// ==== verilog/up_bram.sv ====
// Byte-enabled block RAM on a bus slave port; one-cycle write ack, two-cycle read ack with data.
`default_nettype none

module up_bram
    import up_bram_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    up_bus_if.slave   bus
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              rd_req_d;  // Read strobe delayed by one cycle.
    logic [DATA_W-1:0] rd_temp;   // First stage of the read path.

    // The array powers up cleared.
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.wr_req) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.wr_be[b]) begin
                    mem[bus.wr_addr][b*8 +: 8] <= bus.wr_din[b*8 +: 8];  // Merge enabled byte.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.wr_ack <= 1'b0;
        end else begin
            bus.wr_ack <= bus.wr_req;
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.rd_req) begin
            rd_temp <= mem[bus.rd_addr];
        end
    end

    // Second stage; the output word is held until the next read completes.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req_d    <= 1'b0;
            bus.rd_ack  <= 1'b0;
            bus.rd_dout <= '0;
        end else begin
            rd_req_d   <= bus.rd_req;
            bus.rd_ack <= rd_req_d;  // Ack lines up with the data below.
            if (rd_req_d) begin
                bus.rd_dout <= rd_temp;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks on the strobes from the arbiter
    //////////////////////////////////////////////////

    a_no_rw_overlap : assert property (@(posedge clk) disable iff (rst)
        !(bus.wr_req && bus.rd_req))
        else $error("RAM saw read and write strobes together.");

    a_wr_one_cycle : assert property (@(posedge clk) disable iff (rst)
        bus.wr_req |=> !bus.wr_req)
        else $error("RAM write strobe lasted more than one cycle.");

    a_rd_one_cycle : assert property (@(posedge clk) disable iff (rst)
        bus.rd_req |=> !bus.rd_req)
        else $error("RAM read strobe lasted more than one cycle.");

endmodule

`default_nettype wire

// ==== verilog/up_bram_pkg.sv ====
// Shared widths, memory depth and enum types; imported by every module of the BRAM subsystem.
`default_nettype none

package up_bram_pkg;

    //////////////////////////////////////////////////
    // Widths and depth
    //////////////////////////////////////////////////

    localparam int ADDR_W    = 10;  // Word address width.
    localparam int DATA_W    = 32;  // Data word width.
    localparam int BE_W      = 4;   // One enable per byte of a word.
    localparam int MEM_DEPTH = 1024;

    //////////////////////////////////////////////////
    // Enumerated types
    //////////////////////////////////////////////////

    // Block mover command opcodes.
    typedef enum logic {
        OP_FILL = 1'b0,  // Write the fill value to each word.
        OP_COPY = 1'b1   // Read each source word and write it to the destination.
    } mover_op_e;

    typedef enum logic [1:0] {
        MV_IDLE  = 2'd0,
        MV_READ  = 2'd1,
        MV_WRITE = 2'd2,
        MV_DONE  = 2'd3
    } mover_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ISSUE = 2'd1,
        ARB_WAIT  = 2'd2
    } arb_state_e;

    // Owner of the RAM port.
    typedef enum logic {
        GNT_HOST  = 1'b0,
        GNT_MOVER = 1'b1
    } grant_e;

endpackage

`default_nettype wire

// ==== verilog/up_bram_sys.sv ====
// Top level of the shared BRAM subsystem; host bus and mover command on plain ports.
`default_nettype none

module up_bram_sys
    import up_bram_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    // Host write channel.
    input  wire logic [ADDR_W-1:0] host_wr_addr,
    input  wire logic [BE_W-1:0]   host_wr_be,
    input  wire logic              host_wr_req,
    input  wire logic [DATA_W-1:0] host_wr_din,
    output logic                   host_wr_ack,
    // Host read channel.
    input  wire logic [ADDR_W-1:0] host_rd_addr,
    input  wire logic              host_rd_req,
    output logic [DATA_W-1:0]      host_rd_dout,
    output logic                   host_rd_ack,
    // Mover command.
    input  wire logic              cmd_start,
    input  wire mover_op_e         cmd_op,
    input  wire logic [ADDR_W-1:0] cmd_src,
    input  wire logic [ADDR_W-1:0] cmd_dst,
    input  wire logic [ADDR_W:0]   cmd_len,
    input  wire logic [DATA_W-1:0] cmd_fill,
    output logic                   cmd_busy,
    output logic                   cmd_done
);

    up_bus_if host_bus ();
    up_bus_if mover_bus ();
    up_bus_if mem_bus ();

    //////////////////////////////////////////////////
    // Host ports onto the host bus
    //////////////////////////////////////////////////

    assign host_bus.wr_addr = host_wr_addr;
    assign host_bus.wr_be   = host_wr_be;
    assign host_bus.wr_req  = host_wr_req;
    assign host_bus.wr_din  = host_wr_din;
    assign host_bus.rd_addr = host_rd_addr;
    assign host_bus.rd_req  = host_rd_req;
    assign host_wr_ack      = host_bus.wr_ack;
    assign host_rd_dout     = host_bus.rd_dout;
    assign host_rd_ack      = host_bus.rd_ack;

    //////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////

    block_mover block_mover_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_start (cmd_start),
        .cmd_op    (cmd_op),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .cmd_len   (cmd_len),
        .cmd_fill  (cmd_fill),
        .cmd_busy  (cmd_busy),
        .cmd_done  (cmd_done),
        .bus       (mover_bus.master)
    );

    up_bus_arbiter up_bus_arbiter_i (
        .clk   (clk),
        .rst   (rst),
        .host  (host_bus.slave),
        .mover (mover_bus.slave),
        .mem   (mem_bus.master)
    );

    up_bram up_bram_i (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

endmodule

`default_nettype wire

// ==== verilog/up_bus_arbiter.sv ====
// Round-robin arbiter between host and mover buses; serves one RAM access at a time.
`default_nettype none

module up_bus_arbiter
    import up_bram_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    up_bus_if.slave   host,
    up_bus_if.slave   mover,
    up_bus_if.master  mem
);

    arb_state_e state;
    grant_e     grant;        // Master owning the current access.
    grant_e     last_served;  // Master whose access completed last.
    grant_e     gnt_next;
    logic       host_req;
    logic       mover_req;
    logic       mem_ack;

    assign host_req  = host.wr_req | host.rd_req;
    assign mover_req = mover.wr_req | mover.rd_req;
    assign mem_ack   = mem.wr_ack | mem.rd_ack;

    // On contention the master not served last wins.
    always_comb begin
        if (host_req && mover_req) begin
            gnt_next = (last_served == GNT_HOST) ? GNT_MOVER : GNT_HOST;
        end else if (mover_req) begin
            gnt_next = GNT_MOVER;
        end else begin
            gnt_next = GNT_HOST;
        end
    end

    //////////////////////////////////////////////////
    // Access FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ARB_IDLE;
            grant       <= GNT_HOST;
            last_served <= GNT_MOVER;  // Host wins the first tie.
            mem.wr_req  <= 1'b0;
            mem.rd_req  <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (host_req || mover_req) begin
                        grant <= gnt_next;
                        if (gnt_next == GNT_MOVER) begin
                            mem.wr_req <= mover.wr_req;
                            mem.rd_req <= mover.rd_req;
                        end else begin
                            mem.wr_req <= host.wr_req;
                            mem.rd_req <= host.rd_req;
                        end
                        state <= ARB_ISSUE;
                    end
                end
                ARB_ISSUE: begin
                    mem.wr_req <= 1'b0;  // Strobe lasts a single cycle.
                    mem.rd_req <= 1'b0;
                    state      <= ARB_WAIT;
                end
                ARB_WAIT: begin
                    if (mem_ack) begin
                        last_served <= grant;
                        state       <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Address and data of the granted master, captured with the strobe.
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            mem.wr_addr <= (gnt_next == GNT_MOVER) ? mover.wr_addr : host.wr_addr;
            mem.wr_be   <= (gnt_next == GNT_MOVER) ? mover.wr_be   : host.wr_be;
            mem.wr_din  <= (gnt_next == GNT_MOVER) ? mover.wr_din  : host.wr_din;
            mem.rd_addr <= (gnt_next == GNT_MOVER) ? mover.rd_addr : host.rd_addr;
        end
    end

    //////////////////////////////////////////////////
    // Response routing
    //////////////////////////////////////////////////

    assign host.wr_ack   = mem.wr_ack && (grant == GNT_HOST);
    assign host.rd_ack   = mem.rd_ack && (grant == GNT_HOST);
    assign host.rd_dout  = (grant == GNT_HOST) ? mem.rd_dout : '0;
    assign mover.wr_ack  = mem.wr_ack && (grant == GNT_MOVER);
    assign mover.rd_ack  = mem.rd_ack && (grant == GNT_MOVER);
    assign mover.rd_dout = (grant == GNT_MOVER) ? mem.rd_dout : '0;

    // An ack must land on a request the master is still holding.
    a_ack_while_req : assert property (@(posedge clk) disable iff (rst)
        (host.wr_ack -> host.wr_req) && (host.rd_ack -> host.rd_req) &&
        (mover.wr_ack -> mover.wr_req) && (mover.rd_ack -> mover.rd_req))
        else $error("Ack delivered to a master with no matching request.");

    a_strobe_in_issue : assert property (@(posedge clk) disable iff (rst)
        (mem.wr_req || mem.rd_req) |-> (state == ARB_ISSUE))
        else $error("RAM strobe outside the issue state.");

    a_master_one_req : assert property (@(posedge clk) disable iff (rst)
        !(host.wr_req && host.rd_req) && !(mover.wr_req && mover.rd_req))
        else $error("A master raised read and write together.");

endmodule

`default_nettype wire

// ==== verilog/up_bus_if.sv ====
// Processor-style bus bundle with split write and read channels; master drives requests.
`default_nettype none

interface up_bus_if
    import up_bram_pkg::*;
();

    // Write channel.
    logic [ADDR_W-1:0] wr_addr;
    logic [BE_W-1:0]   wr_be;
    logic              wr_req;
    logic [DATA_W-1:0] wr_din;
    logic              wr_ack;

    // Read channel.
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_req;
    logic [DATA_W-1:0] rd_dout;  // Valid only in the cycle of rd_ack.
    logic              rd_ack;

    modport master (
        output wr_addr,
        output wr_be,
        output wr_req,
        output wr_din,
        input  wr_ack,
        output rd_addr,
        output rd_req,
        input  rd_dout,
        input  rd_ack
    );

    modport slave (
        input  wr_addr,
        input  wr_be,
        input  wr_req,
        input  wr_din,
        output wr_ack,
        input  rd_addr,
        input  rd_req,
        output rd_dout,
        output rd_ack
    );

endinterface

`default_nettype wire
